//--- source/cp0_params.svh
`ifndef CP0_PARAMS_SVH
`define CP0_PARAMS_SVH

// cp0 register numbers
`define CP0_REG_BADVADDR 5'd8
`define CP0_REG_COUNT    5'd9
`define CP0_REG_COMPARE  5'd11
`define CP0_REG_STATUS   5'd12
`define CP0_REG_CAUSE    5'd13
`define CP0_REG_EPC      5'd14
`define CP0_REG_PRID     5'd15
`define CP0_REG_CONFIG   5'd16

// ExcCode field values
`define EXC_INT  5'd0
`define EXC_ADEL 5'd4
`define EXC_ADES 5'd5
`define EXC_SYS  5'd8
`define EXC_BP   5'd9
`define EXC_RI   5'd10
`define EXC_OV   5'd12
`define EXC_TR   5'd13

`define MEM_SIZE_BYTE 2'd0
`define MEM_SIZE_HALF 2'd1
`define MEM_SIZE_WORD 2'd2

`define STATUS_RESET 32'h0040_0000 // BEV only
`define CONFIG_RESET 32'h0000_8000
`define PRID_VALUE   32'h0001_8003
`define EXC_VECTOR   32'hbfc0_0380

`endif

//--- source/cp0_pkg.sv
`default_nettype none

package cp0_pkg;

	// data or address word
	typedef logic [31:0] word_t;

	typedef logic [4:0] cp0_addr_t; // cp0 register number

	typedef logic [4:0] exc_code_t; // Cause ExcCode field

	typedef logic [1:0] mem_size_t; // byte, half or word access

endpackage

`default_nettype wire

//--- source/except_if.sv
`timescale 1ns/1ps
`default_nettype none

interface except_if;
	import cp0_pkg::*;

	logic valid; // one record per strobe
	exc_code_t code;
	word_t pc;
	logic in_delay_slot;
	word_t bad_addr;
	logic is_eret; // eret, not an exception

	modport src (
		output valid,
		output code,
		output pc,
		output in_delay_slot,
		output bad_addr,
		output is_eret
	);

	modport dst (
		input valid,
		input code,
		input pc,
		input in_delay_slot,
		input bad_addr,
		input is_eret
	);

endinterface

`default_nettype wire

//--- source/except_detect.sv
`timescale 1ns/1ps
`default_nettype none

`include "cp0_params.svh"

module except_detect (
	input wire clk,
	input wire arst_n_i,
	input wire stall_i,
	input wire insn_valid_i,
	input wire cp0_pkg::word_t pc_i,
	input wire in_delay_slot_i,
	input wire cp0_pkg::word_t mem_addr_i,
	input wire load_i,
	input wire store_i,
	input wire cp0_pkg::mem_size_t mem_size_i,
	input wire reserved_i,
	input wire overflow_i,
	input wire trap_i,
	input wire syscall_i,
	input wire break_i,
	input wire eret_i,
	input wire cp0_pkg::word_t status_i,
	input wire cp0_pkg::word_t cause_i,
	except_if.src exc
);
	import cp0_pkg::*;

	logic int_pending;
	logic pc_misaligned;
	logic mem_misaligned;
	logic take_exc;
	exc_code_t exc_code;
	word_t exc_bad_addr;

	// IE set, EXL clear, some unmasked IP bit
	assign int_pending = status_i[0] && !status_i[1] && (|(cause_i[15:8] & status_i[15:8]));
	assign pc_misaligned = |pc_i[1:0];

	always_comb begin
		case (mem_size_i)
			`MEM_SIZE_HALF: mem_misaligned = mem_addr_i[0];
			`MEM_SIZE_WORD: mem_misaligned = |mem_addr_i[1:0];
			default: mem_misaligned = 1'b0; // byte access never faults
		endcase
	end

	// fixed priority, highest first
	always_comb begin
		take_exc = 1'b1;
		exc_code = `EXC_INT;
		exc_bad_addr = pc_i;
		if (int_pending) begin
			exc_code = `EXC_INT;
		end else if (pc_misaligned) begin
			exc_code = `EXC_ADEL; // fetch side, bad address is the pc
		end else if (reserved_i) begin
			exc_code = `EXC_RI;
		end else if (overflow_i) begin
			exc_code = `EXC_OV;
		end else if (trap_i) begin
			exc_code = `EXC_TR;
		end else if (syscall_i) begin
			exc_code = `EXC_SYS;
		end else if (break_i) begin
			exc_code = `EXC_BP;
		end else if (load_i && mem_misaligned) begin
			exc_code = `EXC_ADEL;
			exc_bad_addr = mem_addr_i;
		end else if (store_i && mem_misaligned) begin
			exc_code = `EXC_ADES;
			exc_bad_addr = mem_addr_i;
		end else begin
			take_exc = 1'b0;
		end
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			exc.valid <= 1'b0;
			exc.is_eret <= 1'b0;
		end else begin
			exc.valid <= !stall_i && insn_valid_i && (take_exc || eret_i);
			exc.is_eret <= !take_exc && eret_i; // any exception outranks eret
		end
	end

	always_ff @(posedge clk) begin
		if (!stall_i) begin
			exc.code <= exc_code;
			exc.pc <= pc_i;
			exc.in_delay_slot <= in_delay_slot_i;
			exc.bad_addr <= exc_bad_addr;
		end
	end

endmodule

`default_nettype wire

//--- source/cp0_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "cp0_params.svh"

module cp0_regs (
	input wire clk,
	input wire arst_n_i,
	input wire we_i,
	input wire cp0_pkg::cp0_addr_t waddr_i,
	input wire cp0_pkg::word_t wdata_i,
	input wire cp0_pkg::cp0_addr_t raddr_i,
	input wire [4:0] int_i,
	except_if.dst exc,
	output cp0_pkg::word_t rdata_o,
	output cp0_pkg::word_t status_o,
	output cp0_pkg::word_t cause_o,
	output cp0_pkg::word_t epc_o
);
	import cp0_pkg::*;

	word_t count_q;
	logic count_half_q; // count moves on every second clock
	word_t compare_q;
	word_t status_q;
	word_t cause_q;
	word_t epc_q;
	word_t badvaddr_q;
	logic commit_exc;
	logic commit_eret;
	logic timer_hit;
	logic wr_count;
	logic wr_compare;
	logic wr_status;
	logic wr_cause;
	logic wr_epc;

	assign commit_exc = exc.valid && !exc.is_eret;
	assign commit_eret = exc.valid && exc.is_eret;
	assign timer_hit = (compare_q != '0) && (count_q == compare_q);

	assign wr_count = we_i && (waddr_i == `CP0_REG_COUNT);
	assign wr_compare = we_i && (waddr_i == `CP0_REG_COMPARE);
	assign wr_status = we_i && (waddr_i == `CP0_REG_STATUS);
	assign wr_cause = we_i && (waddr_i == `CP0_REG_CAUSE);
	assign wr_epc = we_i && (waddr_i == `CP0_REG_EPC);

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			count_q <= '0;
			count_half_q <= 1'b0;
			compare_q <= '0;
		end else begin
			count_half_q <= !count_half_q;
			if (count_half_q) begin
				count_q <= count_q + 32'd1;
			end
			if (wr_count) begin
				count_q <= wdata_i;
				count_half_q <= 1'b0; // restart the half-rate phase
			end
			if (wr_compare) begin
				compare_q <= wdata_i;
			end
		end
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			status_q <= `STATUS_RESET;
		end else begin
			if (wr_status) begin
				status_q <= wdata_i;
			end
			if (commit_exc) begin
				status_q[1] <= 1'b1; // EXL
			end else if (commit_eret) begin
				status_q[1] <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			cause_q <= '0;
		end else begin
			cause_q[14:10] <= int_i; // IP6:2 follow the pins
			if (wr_compare) begin
				cause_q[15] <= 1'b0; // timer acknowledge
			end else if (timer_hit) begin
				cause_q[15] <= 1'b1;
			end
			if (wr_cause) begin
				cause_q[9:8] <= wdata_i[9:8];
				cause_q[23:22] <= wdata_i[23:22]; // IV and WP
			end
			if (commit_exc) begin
				cause_q[31] <= exc.in_delay_slot;
				cause_q[6:2] <= exc.code;
			end
		end
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			epc_q <= '0;
		end else if (commit_exc) begin
			epc_q <= exc.in_delay_slot ? (exc.pc - 32'd4) : exc.pc; // point at the branch
		end else if (wr_epc) begin
			epc_q <= wdata_i;
		end
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			badvaddr_q <= '0;
		end else if (commit_exc && (exc.code == `EXC_ADEL || exc.code == `EXC_ADES)) begin
			badvaddr_q <= exc.bad_addr;
		end
	end

	// mfc0 port
	always_comb begin
		case (raddr_i)
			`CP0_REG_BADVADDR: rdata_o = badvaddr_q;
			`CP0_REG_COUNT: rdata_o = count_q;
			`CP0_REG_COMPARE: rdata_o = compare_q;
			`CP0_REG_STATUS: rdata_o = status_q;
			`CP0_REG_CAUSE: rdata_o = cause_q;
			`CP0_REG_EPC: rdata_o = epc_q;
			`CP0_REG_PRID: rdata_o = `PRID_VALUE;
			`CP0_REG_CONFIG: rdata_o = `CONFIG_RESET;
			default: rdata_o = '0;
		endcase
	end

	assign status_o = status_q;
	assign cause_o = cause_q;
	assign epc_o = epc_q;

endmodule

`default_nettype wire

//--- source/except_redirect.sv
`timescale 1ns/1ps
`default_nettype none

`include "cp0_params.svh"

module except_redirect (
	input wire clk,
	input wire arst_n_i,
	except_if.dst exc,
	input wire cp0_pkg::word_t epc_i,
	output logic flush_o,
	output cp0_pkg::word_t new_pc_o
);

	// flush lands one cycle after the record, same edge as the cp0 commit
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			flush_o <= 1'b0;
			new_pc_o <= '0;
		end else begin
			flush_o <= exc.valid; // single-cycle pulse
			if (exc.valid) begin
				new_pc_o <= exc.is_eret ? epc_i : `EXC_VECTOR; // epc before any commit
			end
		end
	end

endmodule

`default_nettype wire

//--- source/cp0_top.sv
`timescale 1ns/1ps
`default_nettype none

module cp0_top (
	input wire clk,
	input wire arst_n_i,
	input wire stall_i,
	input wire insn_valid_i,
	input wire cp0_pkg::word_t pc_i,
	input wire in_delay_slot_i,
	input wire cp0_pkg::word_t mem_addr_i,
	input wire load_i,
	input wire store_i,
	input wire cp0_pkg::mem_size_t mem_size_i,
	input wire reserved_i,
	input wire overflow_i,
	input wire trap_i,
	input wire syscall_i,
	input wire break_i,
	input wire eret_i,
	input wire [4:0] int_i,
	input wire cp0_we_i,
	input wire cp0_pkg::cp0_addr_t cp0_waddr_i,
	input wire cp0_pkg::word_t cp0_wdata_i,
	input wire cp0_pkg::cp0_addr_t cp0_raddr_i,
	output cp0_pkg::word_t cp0_rdata_o,
	output logic flush_o,
	output cp0_pkg::word_t new_pc_o
);
	import cp0_pkg::*;

	word_t status_w;
	word_t cause_w;
	word_t epc_w;

	except_if exc_bus ();

	except_detect u_detect (
		.clk(clk),
		.arst_n_i(arst_n_i),
		.stall_i(stall_i),
		.insn_valid_i(insn_valid_i),
		.pc_i(pc_i),
		.in_delay_slot_i(in_delay_slot_i),
		.mem_addr_i(mem_addr_i),
		.load_i(load_i),
		.store_i(store_i),
		.mem_size_i(mem_size_i),
		.reserved_i(reserved_i),
		.overflow_i(overflow_i),
		.trap_i(trap_i),
		.syscall_i(syscall_i),
		.break_i(break_i),
		.eret_i(eret_i),
		.status_i(status_w), // interrupt enable and mask
		.cause_i(cause_w),
		.exc(exc_bus.src)
	);

	cp0_regs u_regs (
		.clk(clk),
		.arst_n_i(arst_n_i),
		.we_i(cp0_we_i),
		.waddr_i(cp0_waddr_i),
		.wdata_i(cp0_wdata_i),
		.raddr_i(cp0_raddr_i),
		.int_i(int_i),
		.exc(exc_bus.dst),
		.rdata_o(cp0_rdata_o),
		.status_o(status_w),
		.cause_o(cause_w),
		.epc_o(epc_w)
	);

	except_redirect u_redirect (
		.clk(clk),
		.arst_n_i(arst_n_i),
		.exc(exc_bus.dst),
		.epc_i(epc_w), // eret target
		.flush_o(flush_o),
		.new_pc_o(new_pc_o)
	);

endmodule

`default_nettype wire

//--- tests/cp0_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "cp0_params.svh"

module cp0_tb;
	import cp0_pkg::*;

	localparam int FLUSH_WAIT = 16;

	logic clk;
	logic arst_n_i;
	logic stall_i;
	logic insn_valid_i;
	word_t pc_i;
	logic in_delay_slot_i;
	word_t mem_addr_i;
	logic load_i;
	logic store_i;
	mem_size_t mem_size_i;
	logic reserved_i;
	logic overflow_i;
	logic trap_i;
	logic syscall_i;
	logic break_i;
	logic eret_i;
	logic [4:0] int_i;
	logic cp0_we_i;
	cp0_addr_t cp0_waddr_i;
	word_t cp0_wdata_i;
	cp0_addr_t cp0_raddr_i;
	word_t cp0_rdata_o;
	logic flush_o;
	word_t new_pc_o;

	int errors;
	word_t rng_state;

	cp0_top uut (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic word_t next_rand();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	task automatic tick();
		@(posedge clk);
		#2;
	endtask

	task automatic clear_insn();
		insn_valid_i = 1'b0;
		pc_i = '0;
		in_delay_slot_i = 1'b0;
		mem_addr_i = '0;
		load_i = 1'b0;
		store_i = 1'b0;
		mem_size_i = `MEM_SIZE_WORD;
		reserved_i = 1'b0;
		overflow_i = 1'b0;
		trap_i = 1'b0;
		syscall_i = 1'b0;
		break_i = 1'b0;
		eret_i = 1'b0;
	endtask

	task automatic write_cp0(input cp0_addr_t addr, input word_t data);
		cp0_we_i = 1'b1;
		cp0_waddr_i = addr;
		cp0_wdata_i = data;
		tick();
		cp0_we_i = 1'b0;
	endtask

	task automatic read_cp0(input cp0_addr_t addr, output word_t data);
		cp0_raddr_i = addr;
		#1;
		data = cp0_rdata_o; // combinational port
		tick();
	endtask

	task automatic expect_word(input string what, input word_t got, input word_t exp);
		if (got !== exp) begin
			errors++;
			$display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic note_failure(input string msg);
		errors++;
		$display("failure at %0t: %s", $time, msg);
	endtask

	// one instruction for one cycle, then wait for the flush
	task automatic issue_insn(input int max_cycles, output logic flushed, output int lat);
		insn_valid_i = 1'b1;
		flushed = 1'b0;
		lat = 0;
		while (!flushed && lat < max_cycles) begin
			tick();
			lat++;
			clear_insn();
			flushed = flush_o;
		end
	endtask

	task automatic take_exception(input word_t exp_pc);
		logic flushed;
		int lat;
		issue_insn(FLUSH_WAIT, flushed, lat);
		if (!flushed) begin
			note_failure("no flush within the timeout");
		end else begin
			expect_word("flush latency", 32'(lat), 32'd2);
			expect_word("new_pc", new_pc_o, exp_pc);
		end
	endtask

	task automatic expect_code(input string what, input exc_code_t code);
		word_t val;
		read_cp0(`CP0_REG_CAUSE, val);
		expect_word(what, 32'(val[6:2]), 32'(code));
	endtask

	task automatic check_reset_values();
		word_t val;
		read_cp0(`CP0_REG_STATUS, val);
		expect_word("reset status", val, `STATUS_RESET);
		read_cp0(`CP0_REG_CONFIG, val);
		expect_word("reset config", val, `CONFIG_RESET);
		read_cp0(`CP0_REG_PRID, val);
		expect_word("reset prid", val, `PRID_VALUE);
		read_cp0(`CP0_REG_CAUSE, val);
		expect_word("reset cause", val, 32'd0);
		read_cp0(`CP0_REG_EPC, val);
		expect_word("reset epc", val, 32'd0);
		read_cp0(5'd3, val); // not implemented
		expect_word("unused register", val, 32'd0);
	endtask

	task automatic check_register_access();
		word_t wr;
		word_t val;
		wr = next_rand();
		write_cp0(`CP0_REG_COMPARE, wr);
		read_cp0(`CP0_REG_COMPARE, val);
		expect_word("compare readback", val, wr);
		wr = next_rand();
		write_cp0(`CP0_REG_STATUS, wr);
		read_cp0(`CP0_REG_STATUS, val);
		expect_word("status readback", val, wr);
		wr = next_rand();
		write_cp0(`CP0_REG_EPC, wr);
		read_cp0(`CP0_REG_EPC, val);
		expect_word("epc readback", val, wr);
		wr = next_rand();
		write_cp0(`CP0_REG_CAUSE, wr);
		read_cp0(`CP0_REG_CAUSE, val);
		expect_word("cause writable bits", val, wr & 32'h00c0_0300); // IV, WP, IP1:0
		write_cp0(`CP0_REG_PRID, next_rand());
		read_cp0(`CP0_REG_PRID, val);
		expect_word("prid after write", val, `PRID_VALUE);
		write_cp0(`CP0_REG_CONFIG, next_rand());
		read_cp0(`CP0_REG_CONFIG, val);
		expect_word("config after write", val, `CONFIG_RESET);
		write_cp0(`CP0_REG_CAUSE, 32'd0);
		write_cp0(`CP0_REG_STATUS, `STATUS_RESET); // interrupts off again
		write_cp0(`CP0_REG_COMPARE, 32'd0);
	endtask

	task automatic check_syscall();
		word_t pc;
		word_t val;
		logic flushed;
		int lat;
		pc = next_rand() & ~32'h3;
		pc_i = pc;
		syscall_i = 1'b1;
		take_exception(`EXC_VECTOR);
		read_cp0(`CP0_REG_EPC, val);
		expect_word("syscall epc", val, pc);
		read_cp0(`CP0_REG_CAUSE, val);
		expect_word("syscall bd", 32'(val[31]), 32'd0);
		expect_word("syscall exccode", 32'(val[6:2]), 32'(`EXC_SYS));
		read_cp0(`CP0_REG_STATUS, val);
		expect_word("syscall exl", 32'(val[1]), 32'd1);
		pc = next_rand() & ~32'h3;
		pc_i = pc;
		in_delay_slot_i = 1'b1;
		syscall_i = 1'b1;
		take_exception(`EXC_VECTOR);
		read_cp0(`CP0_REG_EPC, val);
		expect_word("delay slot epc", val, pc - 32'd4);
		read_cp0(`CP0_REG_CAUSE, val);
		expect_word("delay slot bd", 32'(val[31]), 32'd1);
		stall_i = 1'b1;
		pc_i = next_rand() & ~32'h3;
		syscall_i = 1'b1;
		issue_insn(FLUSH_WAIT, flushed, lat);
		stall_i = 1'b0;
		if (flushed) begin
			note_failure("flush raised for an instruction held by stall_i");
		end
	endtask

	task automatic check_address_errors();
		word_t addr;
		word_t val;
		addr = next_rand() | 32'h1;
		pc_i = next_rand() & ~32'h3;
		load_i = 1'b1;
		mem_size_i = `MEM_SIZE_HALF;
		mem_addr_i = addr;
		take_exception(`EXC_VECTOR);
		expect_code("half load exccode", `EXC_ADEL);
		read_cp0(`CP0_REG_CAUSE, val);
		expect_word("half load bd", 32'(val[31]), 32'd0);
		read_cp0(`CP0_REG_BADVADDR, val);
		expect_word("half load badvaddr", val, addr);
		pc_i = next_rand() & ~32'h3;
		store_i = 1'b1;
		mem_addr_i = (next_rand() & ~32'h3) | 32'h2;
		take_exception(`EXC_VECTOR);
		expect_code("word store exccode", `EXC_ADES);
		addr = (next_rand() & ~32'h3) | 32'h2;
		pc_i = addr;
		take_exception(`EXC_VECTOR);
		expect_code("fetch exccode", `EXC_ADEL);
		read_cp0(`CP0_REG_BADVADDR, val);
		expect_word("fetch badvaddr", val, addr);
		pc_i = next_rand() & ~32'h3;
		overflow_i = 1'b1;
		syscall_i = 1'b1;
		take_exception(`EXC_VECTOR);
		expect_code("overflow over syscall", `EXC_OV);
	endtask

	task automatic check_eret_and_others();
		word_t epc;
		word_t val;
		epc = next_rand() & ~32'h3;
		write_cp0(`CP0_REG_EPC, epc); // return address
		eret_i = 1'b1;
		take_exception(epc);
		read_cp0(`CP0_REG_STATUS, val);
		expect_word("eret exl", 32'(val[1]), 32'd0);
		pc_i = next_rand() & ~32'h3;
		reserved_i = 1'b1;
		take_exception(`EXC_VECTOR);
		expect_code("reserved exccode", `EXC_RI);
		pc_i = next_rand() & ~32'h3;
		break_i = 1'b1;
		take_exception(`EXC_VECTOR);
		expect_code("break exccode", `EXC_BP);
	endtask

	task automatic check_timer();
		word_t val;
		logic flushed;
		int lat;
		int tries;
		write_cp0(`CP0_REG_STATUS, 32'h0040_8001); // BEV, IM7, IE
		read_cp0(`CP0_REG_COUNT, val);
		write_cp0(`CP0_REG_COMPARE, val + 32'd20);
		flushed = 1'b0;
		tries = 0;
		while (!flushed && tries < 100) begin
			pc_i = next_rand() & ~32'h3;
			issue_insn(4, flushed, lat);
			tries++;
		end
		if (!flushed) begin
			note_failure("timer interrupt never raised a flush");
		end else begin
			expect_word("timer new_pc", new_pc_o, `EXC_VECTOR);
			read_cp0(`CP0_REG_CAUSE, val);
			expect_word("timer exccode", 32'(val[6:2]), 32'(`EXC_INT));
			expect_word("timer ip7", 32'(val[15]), 32'd1);
		end
		write_cp0(`CP0_REG_COMPARE, 32'd0); // acknowledge
		read_cp0(`CP0_REG_CAUSE, val);
		expect_word("ip7 after compare write", 32'(val[15]), 32'd0);
	endtask

	initial begin
		errors = 0;
		rng_state = 32'd34689;
		arst_n_i = 1'b0;
		stall_i = 1'b0;
		int_i = '0;
		cp0_we_i = 1'b0;
		cp0_waddr_i = '0;
		cp0_wdata_i = '0;
		cp0_raddr_i = '0;
		clear_insn();
		repeat (10) @(posedge clk);
		#2;
		arst_n_i = 1'b1;
		tick();
		check_reset_values();
		check_register_access();
		check_syscall();
		check_address_errors();
		check_eret_and_others();
		check_timer();
		$display("run complete, %0d errors", errors);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- mips_cp0.f
+incdir+source
source/cp0_pkg.sv
source/except_if.sv
source/except_detect.sv
source/cp0_regs.sv
source/except_redirect.sv
source/cp0_top.sv
tests/cp0_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= cp0_tb
FLIST ?= mips_cp0.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --timescale 1ns/1ps
PASS_MSG ?= All tests passed!

SOURCES := $(wildcard source/*.sv source/*.svh tests/*.sv)
SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
